/* rtl/tcm_pkg.sv */
// tcm bus types and address map
package tcm_pkg;

    // ============================================================
    // bus vector types
    // ============================================================

    typedef logic [31:0] addr_t;  // wishbone byte address
    typedef logic [31:0] data_t;  // wishbone data word
    typedef logic [3:0]  sel_t;   // one lane bit per byte of data_t

    // ============================================================
    // address map
    // ============================================================

    // bank bases aligned to the bank size
    localparam addr_t ITCM_BASE = 32'h0000_0000;
    localparam addr_t DTCM_BASE = 32'h0001_0000;

    // words per bank as a power of two
    localparam int DEF_DEPTH = 512;

    // ============================================================
    // power-up contents
    // ============================================================

    // addi x0, x0, 0 so a core running out of fresh itcm just slides
    localparam data_t ITCM_FILL = 32'h0000_0013;

    // dtcm words power up holding the value one
    localparam data_t DTCM_FILL = 32'h0000_0001;

endpackage

/* rtl/tcm_ram.sv */
// byte-maskable tcm sram
`timescale 1ns/100ps

module tcm_ram #(
    parameter int            DEPTH     = tcm_pkg::DEF_DEPTH,  // words, power of two
    parameter tcm_pkg::data_t FILL_WORD = tcm_pkg::ITCM_FILL   // power-up word value
) (
    input  logic                     clk,
    input  logic                     en,     // access this cycle
    input  logic                     we,     // 1 write, 0 read
    input  tcm_pkg::sel_t            wmask,  // byte lanes to write
    input  logic [$clog2(DEPTH)-1:0] idx,    // word index
    input  tcm_pkg::data_t           wdata,
    output tcm_pkg::data_t           rdata
);

    import tcm_pkg::*;

    localparam int NB = $bits(sel_t);  // bytes per word

    // ============================================================
    // storage and control
    // ============================================================

    data_t mem [DEPTH];                // word array

    logic [$clog2(DEPTH)-1:0] addr_r;  // registered read index

    logic wr_en;
    logic rd_en;

    assign wr_en = en & we;
    assign rd_en = en & ~we;

    // ============================================================
    // write path
    // ============================================================

    // each lane written on its own mask bit
    // unmasked lanes keep their old byte
    always @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NB; b++) begin
                if (wmask[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];  // one byte lane
                end
            end
        end
    end

    // ============================================================
    // read path
    // ============================================================

    // address captured only on enabled reads
    // so rdata holds steady through writes and idle cycles
    always_ff @(posedge clk) begin
        if (rd_en) begin
            addr_r <= idx;
        end
    end

    assign rdata = mem[addr_r];  // data valid the cycle after capture

    // ============================================================
    // power-up fill
    // ============================================================

    initial begin
        for (int w = 0; w < DEPTH; w++) begin
            mem[w] = FILL_WORD;  // every word to the fill pattern
        end
    end

endmodule

/* rtl/tcm_wb_port.sv */
// wishbone classic slave port for one tcm bank
`timescale 1ns/100ps

module tcm_wb_port #(
    parameter int             DEPTH     = tcm_pkg::DEF_DEPTH,  // words in the bank
    parameter tcm_pkg::data_t FILL_WORD = tcm_pkg::ITCM_FILL   // bank power-up word
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stb,    // already qualified by cyc and decode
    input  logic                     we,
    input  tcm_pkg::sel_t            sel,
    input  logic [$clog2(DEPTH)-1:0] idx,
    input  tcm_pkg::data_t           wdata,
    output tcm_pkg::data_t           rdata,
    output logic                     ack
);

    // ============================================================
    // access qualification
    // ============================================================

    // master keeps stb up through the ack cycle
    // only the first sampled edge of a beat reaches the sram
    logic ram_en;

    assign ram_en = stb & ~ack;

    // ============================================================
    // acknowledge
    // ============================================================

    // one cycle after the strobe is first seen
    // self-clearing, so a held strobe gets exactly one ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb & ~ack;  // set on new beat, drop after one cycle
        end
    end

    // ============================================================
    // bank storage
    // ============================================================

    // write lands on the strobe edge
    // read data shows up together with ack
    tcm_ram #(
        .DEPTH     (DEPTH),
        .FILL_WORD (FILL_WORD)
    ) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (we),
        .wmask (sel),    // wishbone sel maps straight to lanes
        .idx   (idx),
        .wdata (wdata),
        .rdata (rdata)   // held after ack until next read
    );

endmodule

/* rtl/tcm_decoder.sv */
// tcm address decoder and response merge
`timescale 1ns/100ps

module tcm_decoder #(
    parameter int             DEPTH          = tcm_pkg::DEF_DEPTH,  // words per bank
    parameter tcm_pkg::addr_t ITCM_BASE_ADDR = tcm_pkg::ITCM_BASE,  // bank-aligned
    parameter tcm_pkg::addr_t DTCM_BASE_ADDR = tcm_pkg::DTCM_BASE   // bank-aligned
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cyc,
    input  logic                     stb,
    input  tcm_pkg::addr_t           adr,
    input  tcm_pkg::data_t           i_rdata,  // from itcm port
    input  logic                     i_ack,
    input  tcm_pkg::data_t           d_rdata,  // from dtcm port
    input  logic                     d_ack,
    output logic                     i_stb,    // to itcm port
    output logic                     d_stb,    // to dtcm port
    output logic [$clog2(DEPTH)-1:0] idx,      // shared word index
    output tcm_pkg::data_t           dat_r,
    output logic                     ack,
    output logic                     err
);

    import tcm_pkg::*;

    // ============================================================
    // address fields
    // ============================================================

    localparam int AW      = $bits(addr_t);
    localparam int IDX_W   = $clog2(DEPTH);
    localparam int TAG_LSB = IDX_W + 2;  // first bit above the word index

    logic req;    // live wishbone beat
    logic i_hit;  // tag matches itcm base
    logic d_hit;  // tag matches dtcm base
    logic miss;   // live beat outside both banks

    // byte offset bits [1:0] are covered by sel
    assign idx = adr[TAG_LSB-1:2];

    // ============================================================
    // bank select
    // ============================================================

    assign req = cyc & stb;

    assign i_hit = (adr[AW-1:TAG_LSB] == ITCM_BASE_ADDR[AW-1:TAG_LSB]);
    assign d_hit = (adr[AW-1:TAG_LSB] == DTCM_BASE_ADDR[AW-1:TAG_LSB]) & ~i_hit;  // itcm wins

    // strobe goes to the selected port only
    assign i_stb = req & i_hit;
    assign d_stb = req & d_hit;

    // unmapped beats strobe neither port, memory untouched
    assign miss = req & ~i_hit & ~d_hit;

    // ============================================================
    // error response
    // ============================================================

    // same one-cycle rule as the bank acks
    // clears itself so a held strobe errors once
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err <= 1'b0;
        end else begin
            err <= miss & ~err;
        end
    end

    // ============================================================
    // response merge
    // ============================================================

    // at most one bank acks per beat
    assign ack = i_ack | d_ack;

    // and-or mux keyed by the acking bank, zero when idle
    assign dat_r = ({$bits(data_t){i_ack}} & i_rdata)
                 | ({$bits(data_t){d_ack}} & d_rdata);

endmodule

/* rtl/tcm_subsystem.sv */
// itcm and dtcm subsystem top
`timescale 1ns/100ps

module tcm_subsystem #(
    parameter int             DEPTH          = tcm_pkg::DEF_DEPTH,  // words per bank
    parameter tcm_pkg::addr_t ITCM_BASE_ADDR = tcm_pkg::ITCM_BASE,
    parameter tcm_pkg::addr_t DTCM_BASE_ADDR = tcm_pkg::DTCM_BASE,
    parameter tcm_pkg::data_t ITCM_FILL_WORD = tcm_pkg::ITCM_FILL,  // nop
    parameter tcm_pkg::data_t DTCM_FILL_WORD = tcm_pkg::DTCM_FILL
) (
    input  logic           clk,
    input  logic           rst_n,
    // wishbone classic slave, faces the core
    input  logic           cyc,
    input  logic           stb,
    input  logic           we,
    input  tcm_pkg::addr_t adr,
    input  tcm_pkg::sel_t  sel,
    input  tcm_pkg::data_t dat_w,
    output tcm_pkg::data_t dat_r,
    output logic           ack,
    output logic           err
);

    import tcm_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    // ============================================================
    // internal nets
    // ============================================================

    logic             i_stb;    // decoded strobes
    logic             d_stb;
    logic [IDX_W-1:0] idx;      // word index to both banks
    data_t            i_rdata;  // bank read data
    data_t            d_rdata;
    logic             i_ack;    // bank acks
    logic             d_ack;

    // ============================================================
    // decoder
    // ============================================================

    tcm_decoder #(
        .DEPTH          (DEPTH),
        .ITCM_BASE_ADDR (ITCM_BASE_ADDR),
        .DTCM_BASE_ADDR (DTCM_BASE_ADDR)
    ) u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .cyc     (cyc),
        .stb     (stb),
        .adr     (adr),
        .i_rdata (i_rdata),
        .i_ack   (i_ack),
        .d_rdata (d_rdata),
        .d_ack   (d_ack),
        .i_stb   (i_stb),
        .d_stb   (d_stb),
        .idx     (idx),
        .dat_r   (dat_r),
        .ack     (ack),
        .err     (err)
    );

    // ============================================================
    // bank ports
    // ============================================================

    // instruction bank, we/sel/dat_w shared with dtcm
    tcm_wb_port #(
        .DEPTH     (DEPTH),
        .FILL_WORD (ITCM_FILL_WORD)
    ) u_itcm (
        .clk   (clk),
        .rst_n (rst_n),
        .stb   (i_stb),
        .we    (we),
        .sel   (sel),
        .idx   (idx),
        .wdata (dat_w),
        .rdata (i_rdata),
        .ack   (i_ack)
    );

    // data bank
    tcm_wb_port #(
        .DEPTH     (DEPTH),
        .FILL_WORD (DTCM_FILL_WORD)
    ) u_dtcm (
        .clk   (clk),
        .rst_n (rst_n),
        .stb   (d_stb),
        .we    (we),
        .sel   (sel),
        .idx   (idx),
        .wdata (dat_w),
        .rdata (d_rdata),
        .ack   (d_ack)
    );

endmodule

/* tb/tcm_checker.sv */
// tcm wishbone protocol checks
`timescale 1ns/100ps

module tcm_checker (
    input logic clk,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic err
);

    // ============================================================
    // response tracking
    // ============================================================

    int   fail_count = 0;  // protocol failures, read by the testbench
    logic resp;            // any slave response this cycle

    assign resp = ack | err;

    // ============================================================
    // wishbone rules at the top-level ports
    // ============================================================

    // one response kind per beat
    resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(ack && err))
        else begin
            fail_count = fail_count + 1;
            $error("ack and err high in the same cycle");
        end

    // response only right after a sampled request
    resp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp |-> $past(cyc && stb))
        else begin
            fail_count = fail_count + 1;
            $error("response without a request in the previous cycle");
        end

    // single-cycle pulse per beat
    resp_single: assert property (@(posedge clk) disable iff (!rst_n) resp |-> !$past(resp))
        else begin
            fail_count = fail_count + 1;
            $error("response held high for two cycles");
        end

    // quiet bus while reset is held
    resp_in_reset: assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> !resp)
        else begin
            fail_count = fail_count + 1;
            $error("response seen during reset");
        end

endmodule

bind tcm_subsystem tcm_checker u_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .err   (err)
);

/* tb/tcm_tb.sv */
// tcm subsystem testbench
`timescale 1ns/100ps

module tcm_tb;

    import tcm_pkg::*;

    // about 330 beats at 3 cycles each plus reset and a wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int N_RANDOM   = 300;

    // ============================================================
    // dut signals and state
    // ============================================================

    logic  clk = 1'b0;
    logic  rst_n;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    sel_t  sel;
    data_t dat_w;
    data_t dat_r;
    logic  ack;
    logic  err;

    data_t itcm_shadow [DEF_DEPTH];  // expected bank contents
    data_t dtcm_shadow [DEF_DEPTH];
    int    errors = 0;
    int    cycles = 0;
    int    seed   = 32'hc8265a54;

    tcm_subsystem uut (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .err   (err)
    );

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ============================================================
    // helpers
    // ============================================================

    // new bytes where sel is set and old bytes elsewhere
    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input sel_t s);
        data_t lane_mask;
        lane_mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~lane_mask) | (new_w & lane_mask);
    endfunction

    // one wishbone beat
    // lat counts falling edges until a response
    task automatic bus_beat(input logic wr, input addr_t a, input sel_t s, input data_t d,
                            output logic got_ack, output logic got_err, output data_t rd,
                            output int lat);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        sel   <= s;
        dat_w <= d;
        lat = 0;
        do begin
            @(negedge clk);  // outputs settled mid-cycle
            lat++;
        end while (!(ack || err));
        got_ack = ack;
        got_err = err;
        rd      = dat_r;
        @(posedge clk);
        cyc <= 1'b0;  // drop after the response and idle one cycle
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    // mapped beat checked against the shadow banks
    task automatic mem_beat(input logic wr, input logic dbank, input int i, input sel_t s,
                            input data_t d);
        addr_t a;
        data_t expv;
        data_t rd;
        logic  got_ack;
        logic  got_err;
        int    lat;
        a    = (dbank ? DTCM_BASE : ITCM_BASE) + addr_t'(i * 4);
        expv = dbank ? dtcm_shadow[i] : itcm_shadow[i];
        bus_beat(wr, a, s, d, got_ack, got_err, rd, lat);
        // response due on the second falling edge
        mem_lat: assert (lat == 2) else begin
            errors++;
            $display("error at time %0t: response %0d cycles after strobe at %h",
                     $time, lat - 1, a);
        end
        mem_resp: assert (got_ack && !got_err) else begin
            errors++;
            $display("error at time %0t: ack=%b err=%b at mapped %h", $time, got_ack,
                     got_err, a);
        end
        if (wr) begin
            if (dbank) dtcm_shadow[i] = merge_bytes(expv, d, s);
            else       itcm_shadow[i] = merge_bytes(expv, d, s);
        end else begin
            mem_data: assert (rd == expv) else begin
                errors++;
                $display("error at time %0t: read %h got %h expected %h", $time, a, rd, expv);
            end
        end
    endtask

    // beat outside both banks needs err and no ack
    task automatic unmapped_beat(input logic wr, input addr_t a, input data_t d);
        data_t rd;
        logic  got_ack;
        logic  got_err;
        int    lat;
        bus_beat(wr, a, 4'hf, d, got_ack, got_err, rd, lat);
        miss_lat: assert (lat == 2) else begin
            errors++;
            $display("error at time %0t: err %0d cycles after strobe at %h", $time, lat - 1, a);
        end
        miss_resp: assert (got_err && !got_ack) else begin
            errors++;
            $display("error at time %0t: ack=%b err=%b at unmapped %h", $time, got_ack,
                     got_err, a);
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    initial begin
        logic [31:0] r;
        data_t       d;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        sel   = '0;
        dat_w = '0;
        for (int w = 0; w < DEF_DEPTH; w++) begin
            itcm_shadow[w] = ITCM_FILL;  // power-up contents
            dtcm_shadow[w] = DTCM_FILL;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // untouched words read back as fill
        mem_beat(1'b0, 1'b0, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b0, 100, 4'hf, '0);
        mem_beat(1'b0, 1'b0, DEF_DEPTH - 1, 4'hf, '0);
        mem_beat(1'b0, 1'b1, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b1, 100, 4'hf, '0);
        mem_beat(1'b0, 1'b1, DEF_DEPTH - 1, 4'hf, '0);

        // full words at both ends and bank independence
        mem_beat(1'b1, 1'b0, 0, 4'hf, 32'hdead_beef);
        mem_beat(1'b0, 1'b1, 0, 4'hf, '0);  // same index in dtcm still fill
        mem_beat(1'b1, 1'b0, DEF_DEPTH - 1, 4'hf, 32'h1234_5678);
        mem_beat(1'b1, 1'b1, 0, 4'hf, 32'hcafe_f00d);
        mem_beat(1'b1, 1'b1, DEF_DEPTH - 1, 4'hf, 32'h0bad_c0de);
        mem_beat(1'b0, 1'b0, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b0, DEF_DEPTH - 1, 4'hf, '0);
        mem_beat(1'b0, 1'b1, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b1, DEF_DEPTH - 1, 4'hf, '0);

        // partial lane writes
        mem_beat(1'b1, 1'b0, 7, 4'b0101, 32'haabb_ccdd);
        mem_beat(1'b0, 1'b0, 7, 4'hf, '0);
        mem_beat(1'b1, 1'b1, 9, 4'b1000, 32'h7700_0000);
        mem_beat(1'b0, 1'b1, 9, 4'hf, '0);
        mem_beat(1'b1, 1'b1, 9, 4'b0110, 32'h00ee_ff00);
        mem_beat(1'b0, 1'b1, 9, 4'hf, '0);

        // a lone strobe without cyc starts no beat
        @(posedge clk);
        stb   <= 1'b1;  // cyc stays low
        we    <= 1'b1;
        adr   <= ITCM_BASE;
        sel   <= 4'hf;
        dat_w <= 32'hffff_ffff;
        @(posedge clk);
        stb <= 1'b0;
        we  <= 1'b0;

        // unmapped beats leave the aliased indices unchanged
        unmapped_beat(1'b1, 32'h0002_0000, 32'hffff_ffff);
        unmapped_beat(1'b0, 32'h0002_0000, '0);
        unmapped_beat(1'b1, DTCM_BASE + addr_t'(DEF_DEPTH * 4) + 32'h24, 32'h5555_5555);
        mem_beat(1'b0, 1'b0, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b1, 0, 4'hf, '0);
        mem_beat(1'b0, 1'b1, 9, 4'hf, '0);

        // random mix over both banks
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            d = $random(seed);
            mem_beat(r[0], r[1], int'((r >> 8) & 32'(DEF_DEPTH - 1)), r[7:4], d);
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d data/response, %0d protocol", errors, uut.u_checker.fail_count);
        if (errors == 0 && uut.u_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/tcm_pkg.sv
rtl/tcm_ram.sv
rtl/tcm_wb_port.sv
rtl/tcm_decoder.sv
rtl/tcm_subsystem.sv
tb/tcm_checker.sv
tb/tcm_tb.sv

/* run.sh */
#!/bin/sh
# build and run the tcm subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tcm_tb \
    -f sources.f \
    -o tcm_sim

# keep running past assertion failures so the closing verdict is printed
./obj_dir/tcm_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: testbench passed"
else
    echo "run.sh: testbench failed, see sim.log"
    exit 1
fi
